/* Bender.yml */
package:
  name: fetch_unit

sources:
  # packages and interface first
  - files:
      - common/isa_pkg.sv
      - common/fetch_pkg.sv
      - common/pair_if.sv
      - rtl/fetch_pc.sv
      - fetch_buffer/fetch_pair.sv
      - fetch_buffer/fetch_steer.sv
      - rtl/fetch_unit.sv

  # testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_fetch_unit.sv

/* common/fetch_pkg.sv */
package fetch_pkg;

	// ======================================================================
	// fetch side types
	// ======================================================================

	// byte address of an instruction
	typedef logic [31:0] pc_t;

	// one fetch buffer slot
	// valid marks a slot that still waits for the instruction queue
	typedef struct packed {
		logic                  valid;
		pc_t                   pc;
		isa_pkg::instruction_t instr;
	} fetch_slot_t;

	// boot address unless the top level overrides it
	localparam pc_t RESET_PC_DEFAULT = 32'h0000_1000;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

	// ======================================================================
	// instruction word layout
	// ======================================================================

	// one 32 bit word per instruction
	// opcode sits in the low bits and the byte displacement in the top half
	typedef struct packed {
		logic [15:0] disp;
		logic [8:0]  operands;
		logic [6:0]  opcode;
	} instruction_t;

	// conditional branch opcode
	localparam logic [6:0] OP_BRANCH = 7'h63;

	// every instruction is one word long
	localparam int unsigned INSN_LEN = 4;

	// ======================================================================
	// branch decode
	// ======================================================================

	// a backward branch is a conditional branch with a negative displacement
	// these are the only ones fetch redirects on by itself
	function automatic logic is_back_branch(input instruction_t insn);
		logic neg;
		neg = insn.disp[15];
		return (insn.opcode == OP_BRANCH) && neg;
	endfunction

	// target is relative to the branch's own address
	// displacement is sign extended to the full address width
	function automatic logic [31:0] branch_target(
		input logic [31:0] pc,
		input instruction_t insn
	);
		logic [31:0] offset;
		offset = {{16{insn.disp[15]}}, insn.disp};
		return pc + offset;
	endfunction

endpackage

/* common/pair_if.sv */
interface pair_if;
	import fetch_pkg::*;

	// ======================================================================
	// steering to buffer pair
	// ======================================================================

	// write both slots of an empty pair
	logic        load;
	fetch_slot_t fill0;
	fetch_slot_t fill1;

	// number of slots taken by the queue this cycle
	// only ever non zero for the head pair
	logic [1:0]  deq_count;

	// drop every slot, wins over load and dequeue
	logic        clear;

	// ======================================================================
	// buffer pair to steering
	// ======================================================================

	// slot0 is the older one
	fetch_slot_t slot0;
	fetch_slot_t slot1;

	// steering side
	modport ctrl (
		output load, fill0, fill1, deq_count, clear,
		input  slot0, slot1
	);

	// storage side
	modport buffer (
		input  load, fill0, fill1, deq_count, clear,
		output slot0, slot1
	);

endinterface

/* fetch_buffer/fetch_pair.sv */
module fetch_pair (
	input logic    clk,
	input logic    rst,
	pair_if.buffer bus
);
	import isa_pkg::*;
	import fetch_pkg::*;

	// slot valid bits
	logic v0;
	logic v1;

	// slot payload
	pc_t          pc0;
	pc_t          pc1;
	instruction_t ins0;
	instruction_t ins1;

	// ======================================================================
	// valid bits
	// ======================================================================

	// clear first, then load, then dequeue
	// load only ever reaches a pair that is empty after this edge
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			v0 <= 1'b0;
			v1 <= 1'b0;
		end else if (bus.clear) begin
			v0 <= 1'b0;
			v1 <= 1'b0;
		end else if (bus.load) begin
			v0 <= bus.fill0.valid;
			v1 <= bus.fill1.valid;
		end else begin
			case (bus.deq_count)
				// only the older slot left, shift the younger one down
				2'd1: begin
					v0 <= v1;
					v1 <= 1'b0;
				end
				2'd2,
				2'd3: begin
					v0 <= 1'b0;
					v1 <= 1'b0;
				end
				default: begin
					v0 <= v0;
					v1 <= v1;
				end
			endcase
		end
	end

	// ======================================================================
	// payload
	// ======================================================================

	// contents only matter while the matching valid bit is set
	always_ff @(posedge clk) begin
		if (bus.load) begin
			pc0  <= bus.fill0.pc;
			ins0 <= bus.fill0.instr;
			pc1  <= bus.fill1.pc;
			ins1 <= bus.fill1.instr;
		end else if (bus.deq_count == 2'd1) begin
			// compaction
			pc0  <= pc1;
			ins0 <= ins1;
		end
	end

	// back to the steering block
	assign bus.slot0 = '{valid: v0, pc: pc0, instr: ins0};
	assign bus.slot1 = '{valid: v1, pc: pc1, instr: ins1};

	// ======================================================================
	// checks
	// ======================================================================

	// the pair stays packed toward slot0 across loads and partial dequeues
	// steering relies on this to judge emptiness from slot0 alone
	a_packed: assert property (
		@(posedge clk) disable iff (rst)
		v1 |-> v0
	) else $error("fetch_pair: slot 1 valid while slot 0 is empty");

endmodule

/* fetch_buffer/fetch_steer.sv */
module fetch_steer (
	input  logic                  clk,
	input  logic                  rst,
	pair_if.ctrl                  pair_a,
	pair_if.ctrl                  pair_b,
	input  logic                  hit,
	input  isa_pkg::instruction_t inst0,
	input  isa_pkg::instruction_t inst1,
	input  logic                  branchmiss,
	input  fetch_pkg::pc_t        misspc,
	input  logic                  room0,
	input  logic                  room1,
	input  fetch_pkg::pc_t        pc,
	output logic                  advance,
	output logic                  redirect,
	output fetch_pkg::pc_t        target,
	output logic                  fetchbuf0_v,
	output isa_pkg::instruction_t fetchbuf0_instr,
	output fetch_pkg::pc_t        fetchbuf0_pc,
	output logic                  fetchbuf1_v,
	output isa_pkg::instruction_t fetchbuf1_instr,
	output fetch_pkg::pc_t        fetchbuf1_pc,
	output logic                  branchback,
	output fetch_pkg::pc_t        backpc
);
	import isa_pkg::*;
	import fetch_pkg::*;

	// 0 selects pair_a as the older pair
	logic        head_sel;
	// head pair slots and the other pair's first slot
	fetch_slot_t h0;
	fetch_slot_t h1;
	fetch_slot_t o0;
	logic        bb0;
	logic        bb1;
	logic        take0;
	logic        take1;
	logic [1:0]  deq;
	logic [1:0]  head_cnt;
	logic        head_drains;
	logic        bb_leave;
	logic        flush;
	logic        fetch_ok;
	logic        load_head;
	logic        load_other;
	fetch_slot_t new0;
	fetch_slot_t new1;

	// ======================================================================
	// head select and queue outputs
	// ======================================================================

	always_comb begin
		if (head_sel) begin
			h0 = pair_b.slot0;
			h1 = pair_b.slot1;
			o0 = pair_a.slot0;
		end else begin
			h0 = pair_a.slot0;
			h1 = pair_a.slot1;
			o0 = pair_b.slot0;
		end
	end

	// backward branch in either head slot
	assign bb0 = h0.valid & is_back_branch(h0.instr);
	assign bb1 = h1.valid & is_back_branch(h1.instr);

	// slot1 is hidden behind a backward branch in slot0
	// it is discarded when that branch leaves
	assign fetchbuf0_v     = h0.valid;
	assign fetchbuf0_instr = h0.instr;
	assign fetchbuf0_pc    = h0.pc;
	assign fetchbuf1_v     = h1.valid & ~bb0;
	assign fetchbuf1_instr = h1.instr;
	assign fetchbuf1_pc    = h1.pc;

	// oldest visible backward branch decides the target
	assign branchback = bb0 | bb1;
	assign backpc     = bb0 ? branch_target(h0.pc, h0.instr) : branch_target(h1.pc, h1.instr);

	// ======================================================================
	// dequeue, flush and load decisions
	// ======================================================================

	// slots taken by the instruction queue at this edge
	assign take0 = fetchbuf0_v & room0;
	assign take1 = fetchbuf1_v & room0 & room1;
	assign deq   = {1'b0, take0} + {1'b0, take1};

	// pairs stay packed so the count tells when the head empties
	assign head_cnt    = {1'b0, h0.valid} + {1'b0, h1.valid};
	assign head_drains = (head_cnt == deq);

	// a departing backward branch throws away everything younger
	assign bb_leave = (bb0 & take0) | (bb1 & take1);
	assign flush    = branchmiss | bb_leave;

	// no fetch while a miss or a backward branch is pending
	// head pair first when it drains, else an empty other pair
	assign fetch_ok   = hit & ~branchmiss & ~branchback;
	assign load_head  = fetch_ok & head_drains;
	assign load_other = fetch_ok & ~head_drains & ~o0.valid;

	// pc control
	assign advance  = load_head | load_other;
	assign redirect = flush;
	assign target   = branchmiss ? misspc : backpc;

	// new pair contents straight from the cache line
	assign new0 = '{valid: 1'b1, pc: pc, instr: inst0};
	assign new1 = '{valid: 1'b1, pc: pc + pc_t'(INSN_LEN), instr: inst1};

	// ======================================================================
	// pair controls
	// ======================================================================

	assign pair_a.load      = head_sel ? load_other : load_head;
	assign pair_b.load      = head_sel ? load_head : load_other;
	assign pair_a.deq_count = head_sel ? 2'd0 : deq;
	assign pair_b.deq_count = head_sel ? deq : 2'd0;
	assign pair_a.clear     = flush;
	assign pair_b.clear     = flush;
	assign pair_a.fill0     = new0;
	assign pair_a.fill1     = new1;
	assign pair_b.fill0     = new0;
	assign pair_b.fill1     = new1;

	// head moves on once it drains and the other pair holds the next slots
	// a flush restarts with pair_a
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			head_sel <= 1'b0;
		end else if (flush) begin
			head_sel <= 1'b0;
		end else if (head_drains && o0.valid) begin
			head_sel <= ~head_sel;
		end
	end

	// the instruction queue reports a second free entry only with a first
	a_room_order: assert property (
		@(posedge clk) disable iff (rst)
		room1 |-> room0
	) else $error("fetch_steer: room1 high while room0 is low");

endmodule

/* rtl/fetch_pc.sv */
module fetch_pc #(
	parameter fetch_pkg::pc_t RESET_PC = fetch_pkg::RESET_PC_DEFAULT
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           advance,
	input  logic           redirect,
	input  fetch_pkg::pc_t target,
	output fetch_pkg::pc_t pc
);
	import isa_pkg::*;
	import fetch_pkg::*;

	// a hit brings in two instructions at once
	localparam pc_t PAIR_STEP = pc_t'(2 * INSN_LEN);

	// ======================================================================
	// address register
	// ======================================================================

	// redirect comes from a branch miss or a departing backward branch
	// advance follows every buffer load
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (redirect) begin
			pc <= target;
		end else if (advance) begin
			pc <= pc + PAIR_STEP;
		end
	end

	// ======================================================================
	// checks
	// ======================================================================

	// steering never loads a pair in the same cycle it redirects
	// otherwise the new target would be skipped by one pair
	a_no_advance_on_redirect: assert property (
		@(posedge clk) disable iff (rst)
		!(advance && redirect)
	) else $error("fetch_pc: advance and redirect high in the same cycle");

endmodule

/* rtl/fetch_unit.sv */
module fetch_unit #(
	parameter fetch_pkg::pc_t RESET_PC = fetch_pkg::RESET_PC_DEFAULT
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  hit,
	input  isa_pkg::instruction_t inst0,
	input  isa_pkg::instruction_t inst1,
	input  logic                  branchmiss,
	input  fetch_pkg::pc_t        misspc,
	input  logic                  room0,
	input  logic                  room1,
	output fetch_pkg::pc_t        pc,
	output logic                  fetchbuf0_v,
	output isa_pkg::instruction_t fetchbuf0_instr,
	output fetch_pkg::pc_t        fetchbuf0_pc,
	output logic                  fetchbuf1_v,
	output isa_pkg::instruction_t fetchbuf1_instr,
	output fetch_pkg::pc_t        fetchbuf1_pc,
	output logic                  branchback,
	output fetch_pkg::pc_t        backpc
);
	import fetch_pkg::*;

	// pc control from the steering block
	logic advance;
	logic redirect;
	pc_t  target;

	// one bus per buffer pair
	pair_if pair_a_bus ();
	pair_if pair_b_bus ();

	// ======================================================================
	// fetch address
	// ======================================================================

	fetch_pc #(
		.RESET_PC(RESET_PC)
	) pc_reg (
		.clk     (clk),
		.rst     (rst),
		.advance (advance),
		.redirect(redirect),
		.target  (target),
		.pc      (pc)
	);

	// ======================================================================
	// buffer pairs
	// ======================================================================

	fetch_pair pair_a (
		.clk(clk),
		.rst(rst),
		.bus(pair_a_bus.buffer)
	);

	fetch_pair pair_b (
		.clk(clk),
		.rst(rst),
		.bus(pair_b_bus.buffer)
	);

	// ======================================================================
	// steering
	// ======================================================================

	fetch_steer steer (
		.clk            (clk),
		.rst            (rst),
		.pair_a         (pair_a_bus.ctrl),
		.pair_b         (pair_b_bus.ctrl),
		.hit            (hit),
		.inst0          (inst0),
		.inst1          (inst1),
		.branchmiss     (branchmiss),
		.misspc         (misspc),
		.room0          (room0),
		.room1          (room1),
		.pc             (pc),
		.advance        (advance),
		.redirect       (redirect),
		.target         (target),
		.fetchbuf0_v    (fetchbuf0_v),
		.fetchbuf0_instr(fetchbuf0_instr),
		.fetchbuf0_pc   (fetchbuf0_pc),
		.fetchbuf1_v    (fetchbuf1_v),
		.fetchbuf1_instr(fetchbuf1_instr),
		.fetchbuf1_pc   (fetchbuf1_pc),
		.branchback     (branchback),
		.backpc         (backpc)
	);

endmodule

/* sim/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ======================================================================
// program memory model
// ======================================================================

// every word is a pure function of its byte address
// word 9 of each 32 word block is a forward branch, an ordinary instruction
// word 27 of every odd 128 byte block loops 3 to 6 instructions back
function automatic logic [31:0] prog_word(input logic [31:0] addr);
	logic [31:0] mix;
	logic [15:0] back;
	mix  = (addr ^ 32'h5bd1_e995) * 32'h9e37_79b9;
	mix  = mix ^ (mix >> 15);
	back = 16'(32'd0 - (32'(addr[9:8]) + 32'd3) * 32'd4);
	if (addr[7] && addr[6:2] == 5'd27) begin
		return {back, mix[15:7], OP_BRANCH};
	end
	if (addr[6:2] == 5'd9) begin
		return {16'h0010, mix[15:7], OP_BRANCH};
	end
	// plain alu style opcodes, never the branch opcode
	return {mix[31:16], mix[15:7], mix[0] ? 7'h13 : 7'h33};
endfunction

// conditional branch with the displacement sign bit set
function automatic logic back_branch(input logic [31:0] w);
	return (w[6:0] == OP_BRANCH) && w[31];
endfunction

// branch address plus the sign extended displacement
function automatic logic [31:0] jump_target(input logic [31:0] addr, input logic [31:0] w);
	return addr + {{16{w[31]}}, w[31:16]};
endfunction

// reference stream, address of the instruction that follows addr
function automatic logic [31:0] next_fetch_pc(input logic [31:0] addr);
	logic [31:0] w;
	w = prog_word(addr);
	if (back_branch(w)) begin
		return jump_target(addr, w);
	end
	return addr + INSN_LEN;
endfunction

`endif

/* sim/tb_fetch_unit.sv */
module tb_fetch_unit;
	import isa_pkg::*;
	import fetch_pkg::*;

	`include "tb_program.svh"

	localparam int  PERIOD       = 4;
	localparam int  RESET_CYCLES = 2;
	localparam pc_t BOOT_PC      = RESET_PC_DEFAULT;
	// departure counts that end each phase
	localparam int  SEQ_INSNS    = 200;
	localparam int  RAND_INSNS   = 400;
	localparam int  TOTAL_INSNS  = 600;
	localparam int  TIMEOUT_CYCLES = TOTAL_INSNS * 20 + RESET_CYCLES;

	logic         clk;
	logic         rst;
	logic         hit;
	instruction_t inst0;
	instruction_t inst1;
	logic         branchmiss;
	pc_t          misspc;
	logic         room0;
	logic         room1;
	pc_t          pc;
	logic         fetchbuf0_v;
	instruction_t fetchbuf0_instr;
	pc_t          fetchbuf0_pc;
	logic         fetchbuf1_v;
	instruction_t fetchbuf1_instr;
	pc_t          fetchbuf1_pc;
	logic         branchback;
	pc_t          backpc;

	// reference stream state
	pc_t          expected_pc;
	pc_t          after_pc;
	int           departed;
	logic         fetching;
	logic         want_bb;
	pc_t          want_back;

	fetch_unit #(
		.RESET_PC(BOOT_PC)
	) fetch_unit_i (
		.clk            (clk),
		.rst            (rst),
		.hit            (hit),
		.inst0          (inst0),
		.inst1          (inst1),
		.branchmiss     (branchmiss),
		.misspc         (misspc),
		.room0          (room0),
		.room1          (room1),
		.pc             (pc),
		.fetchbuf0_v    (fetchbuf0_v),
		.fetchbuf0_instr(fetchbuf0_instr),
		.fetchbuf0_pc   (fetchbuf0_pc),
		.fetchbuf1_v    (fetchbuf1_v),
		.fetchbuf1_instr(fetchbuf1_instr),
		.fetchbuf1_pc   (fetchbuf1_pc),
		.branchback     (branchback),
		.backpc         (backpc)
	);

	always #(PERIOD / 2) clk = ~clk;

	// ======================================================================
	// checking helpers
	// ======================================================================

	task automatic stop_with_failure(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped on a rule violation");
	endtask

	task automatic check_equal(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, want);
			$display("SOME TESTS FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	// one slot leaves for the queue, must be the next one of the stream
	task automatic accept_slot(input pc_t slot_pc, input instruction_t slot_instr);
		check_equal(slot_pc, expected_pc, "departing pc");
		check_equal(slot_instr, prog_word(expected_pc), "departing instruction");
		expected_pc = next_fetch_pc(expected_pc);
		departed    = departed + 1;
	endtask

	// inputs change 1 unit after the edge, instruction words follow pc
	task automatic drive_cycle(input logic h, input logic r0, input logic r1, input logic miss,
		input pc_t mpc);
		@(posedge clk);
		#1;
		hit        = h;
		room0      = r0;
		room1      = r1;
		branchmiss = miss;
		misspc     = mpc;
		inst0      = prog_word(pc);
		inst1      = prog_word(pc + INSN_LEN);
	endtask

	// ======================================================================
	// compare process
	// ======================================================================

	// sampled mid cycle, departures take effect at the next rising edge
	always @(negedge clk) begin
		if (!rst) begin
			if (fetchbuf1_v && !fetchbuf0_v) begin
				stop_with_failure("fetchbuf1_v is high while fetchbuf0_v is low");
			end
			if (!fetching) begin
				check_equal(fetchbuf0_v, 1'b0, "fetchbuf0_v before first hit");
				check_equal(fetchbuf1_v, 1'b0, "fetchbuf1_v before first hit");
				check_equal(branchback, 1'b0, "branchback before first hit");
			end
			// oldest visible backward branch, taken from the reference stream
			// the visible head slots are always the next one or two of the stream
			want_bb   = 1'b0;
			want_back = '0;
			after_pc  = next_fetch_pc(expected_pc);
			if (fetchbuf0_v && back_branch(prog_word(expected_pc))) begin
				want_bb   = 1'b1;
				want_back = after_pc;
			end else if (fetchbuf1_v && back_branch(prog_word(after_pc))) begin
				want_bb   = 1'b1;
				want_back = next_fetch_pc(after_pc);
			end
			check_equal(branchback, want_bb, "branchback");
			if (want_bb) begin
				check_equal(backpc, want_back, "backpc");
			end
			if (fetchbuf0_v && room0) begin
				accept_slot(fetchbuf0_pc, fetchbuf0_instr);
			end
			if (fetchbuf1_v && room0 && room1) begin
				accept_slot(fetchbuf1_pc, fetchbuf1_instr);
			end
			// stream restarts at the miss address
			if (branchmiss) begin
				expected_pc = misspc;
			end
		end
	end

	// ======================================================================
	// watchdog
	// ======================================================================

	initial begin
		#(TIMEOUT_CYCLES * PERIOD);
		$display("Error at %0t: timeout, only %0d of %0d instructions departed",
			$time, departed, TOTAL_INSNS);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// ======================================================================
	// stimulus
	// ======================================================================

	initial begin
		logic r_hit;
		logic r0;
		logic r1;
		logic miss;
		clk         = 1'b0;
		rst         = 1'b1;
		hit         = 1'b0;
		inst0       = '0;
		inst1       = '0;
		branchmiss  = 1'b0;
		misspc      = '0;
		room0       = 1'b0;
		room1       = 1'b0;
		expected_pc = BOOT_PC;
		departed    = 0;
		fetching    = 1'b0;
		void'($urandom(32'h1bee_2251));
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// idle with a ready queue, nothing may show up
		repeat (3) drive_cycle(1'b0, 1'b1, 1'b1, 1'b0, '0);
		check_equal(pc, BOOT_PC, "pc before first hit");
		fetching = 1'b1;

		// full speed, hit and both queue entries every cycle
		while (departed < SEQ_INSNS) begin
			drive_cycle(1'b1, 1'b1, 1'b1, 1'b0, '0);
		end

		// random hits and back-pressure
		while (departed < RAND_INSNS) begin
			r_hit = ($urandom_range(0, 3) != 0);
			r0    = ($urandom_range(0, 2) != 0);
			r1    = r0 && ($urandom_range(0, 1) != 0);
			drive_cycle(r_hit, r0, r1, 1'b0, '0);
		end

		// random branch misses on top, queue closed in a miss cycle
		while (departed < TOTAL_INSNS) begin
			r_hit = ($urandom_range(0, 3) != 0);
			miss  = ($urandom_range(0, 15) == 0);
			if (miss) begin
				drive_cycle(r_hit, 1'b0, 1'b0, 1'b1, BOOT_PC + $urandom_range(0, 1023) * 4);
			end else begin
				r0 = ($urandom_range(0, 2) != 0);
				r1 = r0 && ($urandom_range(0, 1) != 0);
				drive_cycle(r_hit, r0, r1, 1'b0, '0);
			end
		end

		drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+sim
common/isa_pkg.sv
common/fetch_pkg.sv
common/pair_if.sv
rtl/fetch_pc.sv
fetch_buffer/fetch_pair.sv
fetch_buffer/fetch_steer.sv
rtl/fetch_unit.sv
sim/tb_fetch_unit.sv
